//--- hdl/pipeDefs_defs.svh
`ifndef PIPE_DEFS_DEFS_SVH
`define PIPE_DEFS_DEFS_SVH

// data and address width
`define XLEN 32

// register index width, r0 is hardwired to zero
`define REG_ADDR_W 4

// data memory depth in words
`define DMEM_WORDS 64

// cycles from req seen to ack raised
`define MEM_LATENCY 2

// pc step for a sequential instruction
`define INSN_SIZE 4

`endif

//--- hdl/pipeOpPkg.sv
`default_nettype none

`include "pipeDefs_defs.svh"

package pipeOpPkg;

    // one data or address word
    typedef logic [`XLEN-1:0] word_t;

    // integer register index
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    // operation kind as resolved by execute
    typedef enum logic [2:0] {
        OpKindNone,
        OpKindAlu,
        OpKindLoad,
        OpKindStore,
        OpKindBranch,
        OpKindFenceI
    } opKind_t;

    // command to the load/store unit
    typedef enum logic [1:0] {
        LsuCmdNone,
        LsuCmdLoad,
        LsuCmdStore
    } lsuCmd_t;

endpackage

`default_nettype wire

//--- hdl/trapPkg.sv
`default_nettype none

package trapPkg;

    // exception codes, numbered as in the privileged spec
    typedef enum logic [4:0] {
        ExcLoadFault  = 5'd5,
        ExcStoreFault = 5'd7
    } excCode_t;

endpackage

`default_nettype wire

//--- hdl/dataMemory.sv
`default_nettype none
`timescale 1ns/1ps

`include "pipeDefs_defs.svh"

module dataMemory (
    input  logic              clk,
    input  logic              rst,
    input  logic              memReq,
    input  logic              memWrite,
    input  pipeOpPkg::word_t  memAddr,
    input  pipeOpPkg::word_t  memWdata,
    output logic              memAck,
    output logic              memFault,
    output pipeOpPkg::word_t  memRdata
);
    import pipeOpPkg::*;

    localparam int IdxW = $clog2(`DMEM_WORDS);
    localparam int CntW = $clog2(`MEM_LATENCY + 1);
    localparam logic [CntW-1:0] LatLast = CntW'(`MEM_LATENCY - 1);
    localparam logic [`XLEN-3:0] Depth = `DMEM_WORDS;

    word_t mem [0:`DMEM_WORDS-1];
    logic [CntW-1:0] latCnt;
    logic [`XLEN-3:0] wordIdx;
    logic inRange;
    logic ackRise;

    // byte address to word index
    assign wordIdx = memAddr[`XLEN-1:2];
    assign inRange = wordIdx < Depth;
    assign ackRise = memReq && !memAck && (latCnt == LatLast);

    // handshake side: count latency, raise ack, drop it once req is gone
    always_ff @(posedge clk) begin
        if (rst) begin
            memAck <= 1'b0;
            latCnt <= '0;
        end else if (ackRise) begin
            memAck <= 1'b1;
            latCnt <= '0;
        end else if (memReq && !memAck) begin
            latCnt <= latCnt + 1'b1;
        end else if (!memReq) begin
            memAck <= 1'b0;
            latCnt <= '0;
        end
    end

    // access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (ackRise) begin
            memFault <= !inRange;
            memRdata <= inRange ? mem[wordIdx[IdxW-1:0]] : '0;
            if (memWrite && inRange) begin
                mem[wordIdx[IdxW-1:0]] <= memWdata;
            end
        end
    end

    // ack must answer a live request
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(memAck) |-> memReq);

endmodule

`default_nettype wire

//--- hdl/loadStoreUnit.sv
`default_nettype none
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic                clk,
    input  logic                rst,
    input  logic                lsuEnable,
    input  pipeOpPkg::lsuCmd_t  lsuCmd,
    input  pipeOpPkg::word_t    lsuAddr,
    input  pipeOpPkg::word_t    lsuStoreValue,
    output logic                lsuDone,
    output logic                lsuFault,
    output pipeOpPkg::word_t    lsuResult,
    output logic                memReq,
    output logic                memWrite,
    output pipeOpPkg::word_t    memAddr,
    output pipeOpPkg::word_t    memWdata,
    input  logic                memAck,
    input  logic                memFault,
    input  pipeOpPkg::word_t    memRdata
);
    import pipeOpPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Request,
        Release,
        Done
    } lsuState_t;

    lsuState_t state;

    // one transaction per command, four-phase towards the memory
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= Idle;
            memReq <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (lsuEnable) begin
                        state  <= Request;
                        memReq <= 1'b1;
                    end
                end
                Request: begin
                    if (memAck) begin
                        state  <= Release;
                        memReq <= 1'b0;
                    end
                end
                Release: begin
                    // wait for the memory to drop ack
                    if (!memAck) begin
                        state <= Done;
                    end
                end
                // done cycle, enable is not sampled here
                Done: state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

    // request payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == Idle && lsuEnable) begin
            memWrite <= (lsuCmd == LsuCmdStore);
            memAddr  <= lsuAddr;
            memWdata <= lsuStoreValue;
        end
    end

    // capture response while ack is high
    always_ff @(posedge clk) begin
        if (state == Request && memAck) begin
            lsuResult <= memRdata;
            lsuFault  <= memFault;
        end
    end

    assign lsuDone = (state == Done);

    // a new request must wait until the previous ack is gone
    reqAfterAck: assert property (@(posedge clk) disable iff (rst)
        $rose(memReq) |-> !memAck);

endmodule

`default_nettype wire

//--- hdl/memoryAccessStage.sv
`default_nettype none
`timescale 1ns/1ps

`include "pipeDefs_defs.svh"

module memoryAccessStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  pipeOpPkg::opKind_t   inKind,
    input  pipeOpPkg::word_t     inPc,
    input  pipeOpPkg::word_t     inAddr,
    input  pipeOpPkg::word_t     inStoreValue,
    input  pipeOpPkg::word_t     inAluValue,
    input  pipeOpPkg::word_t     inBranchTarget,
    input  pipeOpPkg::regAddr_t  inDstReg,
    input  logic                 inRegWrite,
    input  logic                 inBranchTaken,
    output logic                 stall,
    output logic                 lsuEnable,
    output pipeOpPkg::lsuCmd_t   lsuCmd,
    output pipeOpPkg::word_t     lsuAddr,
    output pipeOpPkg::word_t     lsuStoreValue,
    input  logic                 lsuDone,
    input  logic                 lsuFault,
    input  pipeOpPkg::word_t     lsuResult,
    output logic                 flushReq,
    output pipeOpPkg::word_t     nextPc,
    output logic                 trapValid,
    output trapPkg::excCode_t    trapCause,
    output pipeOpPkg::word_t     trapValue,
    output logic                 wbValid,
    output logic                 wbRegWrite,
    output pipeOpPkg::regAddr_t  wbDstReg,
    output pipeOpPkg::word_t     wbValue
);
    import pipeOpPkg::*;
    import trapPkg::*;

    logic isMemOp;
    logic branchTaken;
    word_t result;

    assign isMemOp     = (inKind == OpKindLoad) || (inKind == OpKindStore);
    assign branchTaken = (inKind == OpKindBranch) && inBranchTaken;

    // kind to unit command
    always_comb begin
        case (inKind)
            OpKindLoad:  lsuCmd = LsuCmdLoad;
            OpKindStore: lsuCmd = LsuCmdStore;
            default:     lsuCmd = LsuCmdNone;
        endcase
    end

    assign lsuEnable     = inValid && isMemOp;
    assign lsuAddr       = inAddr;
    assign lsuStoreValue = inStoreValue;
    assign stall         = lsuEnable && !lsuDone;

    assign result = (inKind == OpKindLoad) ? lsuResult : inAluValue;

    // fault only seen with done, so never while stalled
    assign trapValid = lsuEnable && lsuDone && lsuFault;
    assign trapCause = (inKind == OpKindStore) ? ExcStoreFault : ExcLoadFault;
    assign trapValue = inAddr;

    assign flushReq = inValid && !stall &&
        (branchTaken || inKind == OpKindFenceI || trapValid);
    assign nextPc = branchTaken ? inBranchTarget : inPc + word_t'(`INSN_SIZE);

    // stage register, a stall lets a bubble through
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
        end else begin
            wbValid    <= inValid;
            wbRegWrite <= inRegWrite && !trapValid;
        end
    end

    always_ff @(posedge clk) begin
        wbDstReg <= inDstReg;
        wbValue  <= result;
    end

    // upstream holds the operation while it is stalled
    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(inValid) && $stable(inKind) &&
            $stable(inAddr) && $stable(inStoreValue));

endmodule

`default_nettype wire

//--- hdl/writebackStage.sv
`default_nettype none
`timescale 1ns/1ps

`include "pipeDefs_defs.svh"

module writebackStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wbValid,
    input  logic                 wbRegWrite,
    input  pipeOpPkg::regAddr_t  wbDstReg,
    input  pipeOpPkg::word_t     wbValue,
    input  pipeOpPkg::regAddr_t  rdAddr,
    output pipeOpPkg::word_t     rdData,
    output logic                 retireValid,
    output pipeOpPkg::regAddr_t  retireReg,
    output pipeOpPkg::word_t     retireValue
);
    import pipeOpPkg::*;

    word_t regs [0:(2**`REG_ADDR_W)-1];
    logic writeEn;

    // r0 is never written
    assign writeEn = wbValid && wbRegWrite && (wbDstReg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (writeEn) begin
            regs[wbDstReg] <= wbValue;
        end
    end

    assign rdData = (rdAddr == '0) ? '0 : regs[rdAddr];

    assign retireValid = wbValid;
    assign retireReg   = wbDstReg;
    assign retireValue = writeEn ? wbValue : '0;

endmodule

`default_nettype wire

//--- hdl/memPipeTop.sv
`default_nettype none
`timescale 1ns/1ps

module memPipeTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  pipeOpPkg::opKind_t   inKind,
    input  pipeOpPkg::word_t     inPc,
    input  pipeOpPkg::word_t     inAddr,
    input  pipeOpPkg::word_t     inStoreValue,
    input  pipeOpPkg::word_t     inAluValue,
    input  pipeOpPkg::regAddr_t  inDstReg,
    input  logic                 inRegWrite,
    input  logic                 inBranchTaken,
    input  pipeOpPkg::word_t     inBranchTarget,
    output logic                 stall,
    output logic                 flushReq,
    output pipeOpPkg::word_t     nextPc,
    output logic                 trapValid,
    output trapPkg::excCode_t    trapCause,
    output pipeOpPkg::word_t     trapValue,
    input  pipeOpPkg::regAddr_t  rdAddr,
    output pipeOpPkg::word_t     rdData,
    output logic                 retireValid,
    output pipeOpPkg::regAddr_t  retireReg,
    output pipeOpPkg::word_t     retireValue
);
    import pipeOpPkg::*;

    // stage to unit
    logic lsuEnable;
    logic lsuDone;
    logic lsuFault;
    lsuCmd_t lsuCmd;
    word_t lsuAddr;
    word_t lsuStoreValue;
    word_t lsuResult;

    // unit to memory
    logic memReq;
    logic memWrite;
    logic memAck;
    logic memFault;
    word_t memAddr;
    word_t memWdata;
    word_t memRdata;

    // stage register
    logic wbValid;
    logic wbRegWrite;
    regAddr_t wbDstReg;
    word_t wbValue;

    memoryAccessStage i_memoryAccessStage (
        .clk            (clk),
        .rst            (rst),
        .inValid        (inValid),
        .inKind         (inKind),
        .inPc           (inPc),
        .inAddr         (inAddr),
        .inStoreValue   (inStoreValue),
        .inAluValue     (inAluValue),
        .inBranchTarget (inBranchTarget),
        .inDstReg       (inDstReg),
        .inRegWrite     (inRegWrite),
        .inBranchTaken  (inBranchTaken),
        .stall          (stall),
        .lsuEnable      (lsuEnable),
        .lsuCmd         (lsuCmd),
        .lsuAddr        (lsuAddr),
        .lsuStoreValue  (lsuStoreValue),
        .lsuDone        (lsuDone),
        .lsuFault       (lsuFault),
        .lsuResult      (lsuResult),
        .flushReq       (flushReq),
        .nextPc         (nextPc),
        .trapValid      (trapValid),
        .trapCause      (trapCause),
        .trapValue      (trapValue),
        .wbValid        (wbValid),
        .wbRegWrite     (wbRegWrite),
        .wbDstReg       (wbDstReg),
        .wbValue        (wbValue)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk           (clk),
        .rst           (rst),
        .lsuEnable     (lsuEnable),
        .lsuCmd        (lsuCmd),
        .lsuAddr       (lsuAddr),
        .lsuStoreValue (lsuStoreValue),
        .lsuDone       (lsuDone),
        .lsuFault      (lsuFault),
        .lsuResult     (lsuResult),
        .memReq        (memReq),
        .memWrite      (memWrite),
        .memAddr       (memAddr),
        .memWdata      (memWdata),
        .memAck        (memAck),
        .memFault      (memFault),
        .memRdata      (memRdata)
    );

    dataMemory i_dataMemory (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memAck   (memAck),
        .memFault (memFault),
        .memRdata (memRdata)
    );

    writebackStage i_writebackStage (
        .clk         (clk),
        .rst         (rst),
        .wbValid     (wbValid),
        .wbRegWrite  (wbRegWrite),
        .wbDstReg    (wbDstReg),
        .wbValue     (wbValue),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireValue (retireValue)
    );

endmodule

`default_nettype wire

//--- dv/memPipeTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "pipeDefs_defs.svh"

module memPipeTb;
    import pipeOpPkg::*;
    import trapPkg::*;

    localparam int StallLimit = 50;
    localparam int IdxW = $clog2(`DMEM_WORDS);

    typedef struct {
        opKind_t  kind;
        word_t    addr;
        regAddr_t dst;
        logic     regWrite;
        logic     taken;
        word_t    target;
        word_t    pc;
    } row_t;

    logic clk;
    logic rst;
    logic inValid;
    opKind_t inKind;
    word_t inPc;
    word_t inAddr;
    word_t inStoreValue;
    word_t inAluValue;
    regAddr_t inDstReg;
    logic inRegWrite;
    logic inBranchTaken;
    word_t inBranchTarget;
    logic stall;
    logic flushReq;
    word_t nextPc;
    logic trapValid;
    excCode_t trapCause;
    word_t trapValue;
    regAddr_t rdAddr;
    word_t rdData;
    logic retireValid;
    regAddr_t retireReg;
    word_t retireValue;

    row_t rows [$];
    word_t shadowMem [`DMEM_WORDS];
    word_t shadowRegs [2**`REG_ADDR_W];
    int errors;
    int applied;
    logic timedOut;

    memPipeTop i_memPipeTop (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // present one row, wait for acceptance, then check the retire cycle
    task automatic applyRow(input row_t r);
        word_t storeVal;
        word_t aluVal;
        word_t wordIdx;
        word_t expValue;
        word_t expNextPc;
        logic isMem;
        logic fault;
        logic taken;
        logic expFlush;
        logic expWrite;
        int waitCycles;
        storeVal = $urandom;
        aluVal = $urandom;
        wordIdx = r.addr >> 2;
        isMem = (r.kind == OpKindLoad) || (r.kind == OpKindStore);
        fault = isMem && (wordIdx >= `DMEM_WORDS);
        taken = (r.kind == OpKindBranch) && r.taken;
        expFlush = taken || (r.kind == OpKindFenceI) || fault;
        expNextPc = taken ? r.target : r.pc + `INSN_SIZE;
        expWrite = r.regWrite && !fault && (r.dst != '0);
        if (r.kind == OpKindLoad && !fault) begin
            expValue = shadowMem[wordIdx[IdxW-1:0]];
        end else begin
            expValue = aluVal;
        end

        inValid = 1'b1;
        inKind = r.kind;
        inPc = r.pc;
        inAddr = r.addr;
        inStoreValue = storeVal;
        inAluValue = aluVal;
        inDstReg = r.dst;
        inRegWrite = r.regWrite;
        inBranchTaken = r.taken;
        inBranchTarget = r.target;
        #1;
        if (stall !== isMem) begin
            $display("ERR stall expected %h got %h", isMem, stall);
            errors++;
        end

        // memory ops hold stall, no retire may slip through meanwhile
        waitCycles = 0;
        while (stall && waitCycles < StallLimit) begin
            @(negedge clk);
            #1;
            waitCycles++;
            if (retireValid !== 1'b0) begin
                $display("ERR retireValid expected 0 got %h", retireValid);
                errors++;
            end
        end
        if (stall) begin
            $display("timeout: stall stayed high for the row at pc %h", r.pc);
            errors++;
            timedOut = 1'b1;
            return;
        end

        if (flushReq !== expFlush) begin
            $display("ERR flushReq expected %h got %h", expFlush, flushReq);
            errors++;
        end
        if (expFlush && nextPc !== expNextPc) begin
            $display("ERR nextPc expected %h got %h", expNextPc, nextPc);
            errors++;
        end
        if (trapValid !== fault) begin
            $display("ERR trapValid expected %h got %h", fault, trapValid);
            errors++;
        end
        if (fault) begin
            if (trapCause !== ((r.kind == OpKindStore) ? ExcStoreFault : ExcLoadFault)) begin
                $display("ERR trapCause expected %h got %h",
                    (r.kind == OpKindStore) ? ExcStoreFault : ExcLoadFault, trapCause);
                errors++;
            end
            if (trapValue !== r.addr) begin
                $display("ERR trapValue expected %h got %h", r.addr, trapValue);
                errors++;
            end
        end

        // accepting edge lies between here and the next falling edge
        @(negedge clk);
        if (retireValid !== 1'b1) begin
            $display("ERR retireValid expected 1 got %h", retireValid);
            errors++;
        end
        if (retireReg !== r.dst) begin
            $display("ERR retireReg expected %h got %h", r.dst, retireReg);
            errors++;
        end
        if (retireValue !== (expWrite ? expValue : '0)) begin
            $display("ERR retireValue expected %h got %h",
                expWrite ? expValue : '0, retireValue);
            errors++;
        end

        if (r.kind == OpKindStore && !fault) begin
            shadowMem[wordIdx[IdxW-1:0]] = storeVal;
        end
        if (expWrite) begin
            shadowRegs[r.dst] = expValue;
        end
        applied++;
    endtask

    initial begin
        regAddr_t ra;
        void'($urandom(32'h67ce_243f));
        errors = 0;
        applied = 0;
        timedOut = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inKind = OpKindNone;
        inPc = '0;
        inAddr = '0;
        inStoreValue = '0;
        inAluValue = '0;
        inDstReg = '0;
        inRegWrite = 1'b0;
        inBranchTaken = 1'b0;
        inBranchTarget = '0;
        rdAddr = '0;
        shadowMem = '{default: '0};
        shadowRegs = '{default: '0};

        // kind, addr, dst, regWrite, taken, target, pc
        rows.push_back(row_t'{OpKindStore,  32'h0000, 4'd0,  1'b0, 1'b0, 32'h0,    32'h100});
        rows.push_back(row_t'{OpKindLoad,   32'h0000, 4'd1,  1'b1, 1'b0, 32'h0,    32'h104});
        rows.push_back(row_t'{OpKindAlu,    32'h0000, 4'd2,  1'b1, 1'b0, 32'h0,    32'h108});
        rows.push_back(row_t'{OpKindAlu,    32'h0000, 4'd0,  1'b1, 1'b0, 32'h0,    32'h10c});
        rows.push_back(row_t'{OpKindStore,  32'h003c, 4'd0,  1'b0, 1'b0, 32'h0,    32'h110});
        rows.push_back(row_t'{OpKindAlu,    32'h0000, 4'd3,  1'b1, 1'b0, 32'h0,    32'h114});
        rows.push_back(row_t'{OpKindLoad,   32'h003c, 4'd4,  1'b1, 1'b0, 32'h0,    32'h118});
        // 0x100 is word 64, aliases word 0 if the range check were missing
        rows.push_back(row_t'{OpKindStore,  32'h0100, 4'd0,  1'b0, 1'b0, 32'h0,    32'h11c});
        rows.push_back(row_t'{OpKindLoad,   32'h0400, 4'd5,  1'b1, 1'b0, 32'h0,    32'h120});
        rows.push_back(row_t'{OpKindLoad,   32'h0000, 4'd6,  1'b1, 1'b0, 32'h0,    32'h124});
        rows.push_back(row_t'{OpKindBranch, 32'h0000, 4'd0,  1'b0, 1'b1, 32'h2000, 32'h128});
        rows.push_back(row_t'{OpKindBranch, 32'h0000, 4'd0,  1'b0, 1'b0, 32'h3000, 32'h2000});
        rows.push_back(row_t'{OpKindFenceI, 32'h0000, 4'd0,  1'b0, 1'b0, 32'h0,    32'h2004});
        rows.push_back(row_t'{OpKindStore,  32'h00fc, 4'd0,  1'b0, 1'b0, 32'h0,    32'h2008});
        rows.push_back(row_t'{OpKindLoad,   32'h00fc, 4'd7,  1'b1, 1'b0, 32'h0,    32'h200c});
        rows.push_back(row_t'{OpKindAlu,    32'h0000, 4'd15, 1'b1, 1'b0, 32'h0,    32'h2010});

        repeat (3) @(negedge clk);
        rst = 1'b0;
        if (stall || retireValid || flushReq || trapValid ||
            i_memPipeTop.memReq || i_memPipeTop.memAck) begin
            $display("a control output was still high right after reset");
            errors++;
        end

        foreach (rows[n]) begin
            if (!timedOut) begin
                applyRow(rows[n]);
            end
        end
        inValid = 1'b0;
        inKind = OpKindNone;

        // let the last write land, then read back every register
        if (!timedOut) begin
            @(negedge clk);
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                ra = regAddr_t'(i);
                rdAddr = ra;
                #1;
                if (rdData !== shadowRegs[ra]) begin
                    $display("ERR rdData[%0d] expected %h got %h", i, shadowRegs[ra], rdData);
                    errors++;
                end
                @(negedge clk);
            end
        end

        $display("rows applied %0d, errors %0d", applied, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/pipeOpPkg.sv
hdl/trapPkg.sv
hdl/dataMemory.sv
hdl/loadStoreUnit.sv
hdl/memoryAccessStage.sv
hdl/writebackStage.sv
hdl/memPipeTop.sv
dv/memPipeTb.sv

//--- run.sh
#!/bin/sh
# build and run the memory pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module memPipeTb \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VmemPipeTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
